// ==== bus_request_unit.sv ====
// Shared memory bus master, registers one fetch or data request and routes its response back
`timescale 1ns/1ps

module bus_request_unit (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              fetch_req_i,
  input  logic [31:0]       fetch_addr_i,
  input  logic              data_req_i,
  input  cpu_pkg::bus_req_t data_req_bundle_i,
  output logic              done_o,
  output cpu_pkg::bus_rsp_t rsp_o,
  output cpu_pkg::bus_req_t bus_req_o,
  output logic              bus_req_valid_o,
  input  logic              bus_req_ready_i,
  input  logic              bus_rsp_valid_i,
  input  cpu_pkg::bus_rsp_t bus_rsp_i
);
  import cpu_pkg::*;

  bus_req_t fetch_bundle;
  bus_req_t req_q;
  logic     valid_q;
  logic     outstanding_q;
  logic     idle;

  // Instruction fetch is always a full-word read
  always_comb begin
    fetch_bundle.addr  = fetch_addr_i;
    fetch_bundle.wdata = '0;
    fetch_bundle.sel   = 4'b1111;
    fetch_bundle.write = 1'b0;
  end

  assign idle = !valid_q && !outstanding_q;

  // Request payload only changes while nothing is in flight
  always_ff @(posedge clk) begin
    if (idle && data_req_i) begin
      req_q <= data_req_bundle_i;
    end else if (idle && fetch_req_i) begin
      req_q <= fetch_bundle;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q       <= 1'b0;
      outstanding_q <= 1'b0;
    end else begin
      if (idle && (fetch_req_i || data_req_i)) begin
        valid_q <= 1'b1;
      end else if (valid_q && bus_req_ready_i) begin
        valid_q       <= 1'b0;
        outstanding_q <= 1'b1;
      end else if (outstanding_q && bus_rsp_valid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  assign bus_req_o       = req_q;
  assign bus_req_valid_o = valid_q;
  assign done_o          = outstanding_q && bus_rsp_valid_i;
  assign rsp_o           = bus_rsp_i;

  req_stable_a: assert property (@(posedge clk) disable iff (rst_i)
    bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_o));

  // Memory must not answer a request it never accepted
  rsp_expected_a: assert property (@(posedge clk) disable iff (rst_i)
    bus_rsp_valid_i |-> outstanding_q);

endmodule

// ==== core_sequencer.sv ====
// Multicycle control FSM of the core, owns the PC, instruction register and load data register
`timescale 1ns/1ps
`include "cpu_consts.svh"

module core_sequencer (
  input  logic              clk,
  input  logic              rst_i,
  input  cpu_pkg::decoded_t dec_i,
  input  logic [31:0]       next_pc_i,
  input  logic              done_i,
  input  cpu_pkg::bus_rsp_t rsp_i,
  output logic              fetch_req_o,
  output logic              data_req_o,
  output logic [31:0]       pc_o,
  output logic [31:0]       instr_o,
  output logic [31:0]       load_data_o,
  output logic              reg_we_o,
  output logic              halted_o
);
  import cpu_pkg::*;

  seq_state_e  state_q;
  seq_state_e  state_d;
  logic [31:0] pc_q;
  logic [31:0] ir_q;
  logic [31:0] load_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FETCH:      state_d = S_FETCH_WAIT;
      S_FETCH_WAIT: state_d = done_i ? S_EXECUTE : S_FETCH_WAIT;
      S_EXECUTE: begin
        if (dec_i.halt) begin
          state_d = S_HALTED;
        end else if (dec_i.mem_read || dec_i.mem_write) begin
          state_d = S_MEM;
        end else begin
          state_d = S_WRITEBACK;
        end
      end
      S_MEM:        state_d = S_MEM_WAIT;
      S_MEM_WAIT:   state_d = done_i ? S_WRITEBACK : S_MEM_WAIT;
      S_WRITEBACK:  state_d = S_FETCH;
      S_HALTED:     state_d = S_HALTED;
      default:      state_d = S_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_FETCH;
      pc_q    <= `CPU_RESET_PC;
    end else begin
      state_q <= state_d;
      if (state_q == S_WRITEBACK) begin
        pc_q <= next_pc_i;
      end
    end
  end

  // Instruction and load data captured on their responses
  always_ff @(posedge clk) begin
    if (state_q == S_FETCH_WAIT && done_i) begin
      ir_q <= rsp_i.rdata;
    end
    if (state_q == S_MEM_WAIT && done_i) begin
      load_q <= rsp_i.rdata;
    end
  end

  assign fetch_req_o = (state_q == S_FETCH);
  assign data_req_o  = (state_q == S_MEM);
  assign pc_o        = pc_q;
  assign instr_o     = ir_q;
  assign load_data_o = load_q;
  assign reg_we_o    = (state_q == S_WRITEBACK) && dec_i.reg_write && (dec_i.rd != 5'd0);
  assign halted_o    = (state_q == S_HALTED);

  done_in_wait_a: assert property (@(posedge clk) disable iff (rst_i)
    done_i |-> state_q inside {S_FETCH_WAIT, S_MEM_WAIT});

endmodule

// ==== cpu_consts.svh ====
// Core-wide constants for the RV32I core, pulled in with `include by the package and the RTL
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// PC value loaded on reset
`define CPU_RESET_PC 32'h0000_0000

// Machine word width
`define CPU_XLEN 32

// Architectural register count, x0 included
`define CPU_NUM_REGS 32

// External memory bus
`define CPU_BUS_ADDR_W 32
`define CPU_BUS_DATA_W 32
`define CPU_BUS_SEL_W 4

`endif

// ==== cpu_pkg.sv ====
// Shared enums and packed structs of the RV32I core, imported by every RTL block
`include "cpu_consts.svh"

package cpu_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
  } branch_e;

  typedef enum logic [1:0] {
    MW_BYTE = 2'b00,
    MW_HALF = 2'b01,
    MW_WORD = 2'b10
  } mem_width_e;

  typedef enum logic [2:0] {
    S_FETCH, S_FETCH_WAIT, S_EXECUTE, S_MEM, S_MEM_WAIT, S_WRITEBACK, S_HALTED
  } seq_state_e;

  // Everything the datapath needs to know about the held instruction
  typedef struct packed {
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    alu_op_e              alu_op;
    branch_e              branch;
    mem_width_e           mem_width;
    logic                 load_unsigned;
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;
    logic                 alu_src_imm;
    logic                 a1_pc;
    logic                 link;
    logic                 jalr;
    logic                 halt;
    logic [`CPU_XLEN-1:0] imm;
  } decoded_t;

  typedef struct packed {
    logic [`CPU_BUS_ADDR_W-1:0] addr;
    logic [`CPU_BUS_DATA_W-1:0] wdata;
    logic [`CPU_BUS_SEL_W-1:0]  sel;
    logic                       write;
  } bus_req_t;

  typedef struct packed {
    logic [`CPU_BUS_DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

// ==== cpu_top.sv ====
// Top level of the multicycle RV32I core, ties the datapath blocks to one memory bus
`timescale 1ns/1ps

module cpu_top (
  input  logic              clk,
  input  logic              rst_i,
  output cpu_pkg::bus_req_t bus_req_o,
  output logic              bus_req_valid_o,
  input  logic              bus_req_ready_i,
  input  logic              bus_rsp_valid_i,
  input  cpu_pkg::bus_rsp_t bus_rsp_i,
  output logic              halted_o
);
  import cpu_pkg::*;

  decoded_t    dec;
  bus_req_t    data_req_bundle;
  bus_rsp_t    rsp;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] alu_result;
  logic [31:0] next_pc;
  logic [31:0] wb_data;
  logic [31:0] pc;
  logic [31:0] instr;
  logic [31:0] load_data;
  logic        fetch_req;
  logic        data_req;
  logic        reg_we;
  logic        done;

  instr_decode i_instr_decode (
    .instr_i (instr),
    .dec_o   (dec)
  );

  register_file i_register_file (
    .clk      (clk),
    .rst_i    (rst_i),
    .rs1_i    (dec.rs1),
    .rs2_i    (dec.rs2),
    .we_i     (reg_we),
    .rd_i     (dec.rd),
    .wdata_i  (wb_data),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  execute_unit i_execute_unit (
    .dec_i        (dec),
    .pc_i         (pc),
    .rs1_val_i    (rdata1),
    .rs2_val_i    (rdata2),
    .alu_result_o (alu_result),
    .next_pc_o    (next_pc)
  );

  result_stage i_result_stage (
    .dec_i        (dec),
    .alu_result_i (alu_result),
    .rs2_val_i    (rdata2),
    .pc_i         (pc),
    .load_data_i  (load_data),
    .data_req_o   (data_req_bundle),
    .wb_data_o    (wb_data)
  );

  bus_request_unit i_bus_request_unit (
    .clk               (clk),
    .rst_i             (rst_i),
    .fetch_req_i       (fetch_req),
    .fetch_addr_i      (pc),
    .data_req_i        (data_req),
    .data_req_bundle_i (data_req_bundle),
    .done_o            (done),
    .rsp_o             (rsp),
    .bus_req_o         (bus_req_o),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_rsp_valid_i   (bus_rsp_valid_i),
    .bus_rsp_i         (bus_rsp_i)
  );

  core_sequencer i_core_sequencer (
    .clk         (clk),
    .rst_i       (rst_i),
    .dec_i       (dec),
    .next_pc_i   (next_pc),
    .done_i      (done),
    .rsp_i       (rsp),
    .fetch_req_o (fetch_req),
    .data_req_o  (data_req),
    .pc_o        (pc),
    .instr_o     (instr),
    .load_data_o (load_data),
    .reg_we_o    (reg_we),
    .halted_o    (halted_o)
  );

endmodule

// ==== execute_unit.sv ====
// ALU, branch compare and next-PC logic of the core, purely combinational
`timescale 1ns/1ps

module execute_unit (
  input  cpu_pkg::decoded_t dec_i,
  input  logic [31:0]       pc_i,
  input  logic [31:0]       rs1_val_i,
  input  logic [31:0]       rs2_val_i,
  output logic [31:0]       alu_result_o,
  output logic [31:0]       next_pc_o
);
  import cpu_pkg::*;

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic        eq;
  logic        lt;
  logic        ltu;
  logic        taken;

  assign op_a  = dec_i.a1_pc ? pc_i : rs1_val_i;
  assign op_b  = dec_i.alu_src_imm ? dec_i.imm : rs2_val_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:    alu_result_o = op_a + op_b;
      ALU_SUB:    alu_result_o = op_a - op_b;
      ALU_SLL:    alu_result_o = op_a << shamt;
      ALU_SLT:    alu_result_o = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result_o = {31'd0, op_a < op_b};
      ALU_XOR:    alu_result_o = op_a ^ op_b;
      ALU_SRL:    alu_result_o = op_a >> shamt;
      ALU_SRA:    alu_result_o = $signed(op_a) >>> shamt;
      ALU_OR:     alu_result_o = op_a | op_b;
      ALU_AND:    alu_result_o = op_a & op_b;
      ALU_PASS_B: alu_result_o = op_b;
      default:    alu_result_o = op_a + op_b;
    endcase
  end

  // Branch compare always on the register operands
  assign eq  = (rs1_val_i == rs2_val_i);
  assign lt  = ($signed(rs1_val_i) < $signed(rs2_val_i));
  assign ltu = (rs1_val_i < rs2_val_i);

  always_comb begin
    case (dec_i.branch)
      BR_EQ:   taken = eq;
      BR_NE:   taken = !eq;
      BR_LT:   taken = lt;
      BR_GE:   taken = !lt;
      BR_LTU:  taken = ltu;
      BR_GEU:  taken = !ltu;
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // JALR target comes from the ALU sum rs1+imm
  always_comb begin
    if (dec_i.jalr) begin
      next_pc_o = {alu_result_o[31:1], 1'b0};
    end else if (taken) begin
      next_pc_o = pc_i + dec_i.imm;
    end else begin
      next_pc_o = pc_i + 32'd4;
    end
  end

endmodule

// ==== instr_decode.sv ====
// Combinational RV32I decoder that turns the held instruction word into control fields and an immediate
`timescale 1ns/1ps

module instr_decode (
  input  logic [31:0]       instr_i,
  output cpu_pkg::decoded_t dec_o
);
  import cpu_pkg::*;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  alu_op_e     arith_op;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  // Immediate formats
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'h000};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Bit 30 picks SUB in the register form only and SRA in both forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = instr_i[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    dec_o           = '0;
    dec_o.rs1       = instr_i[19:15];
    dec_o.rs2       = instr_i[24:20];
    dec_o.rd        = instr_i[11:7];
    dec_o.alu_op    = ALU_ADD;
    dec_o.branch    = BR_NONE;
    dec_o.mem_width = MW_WORD;
    case (opcode)
      OPC_LUI: begin
        dec_o.alu_op      = ALU_PASS_B;
        dec_o.alu_src_imm = 1'b1;
        dec_o.reg_write   = 1'b1;
        dec_o.imm         = imm_u;
      end
      OPC_AUIPC: begin
        dec_o.a1_pc       = 1'b1;
        dec_o.alu_src_imm = 1'b1;
        dec_o.reg_write   = 1'b1;
        dec_o.imm         = imm_u;
      end
      OPC_JAL: begin
        dec_o.branch    = BR_JUMP;
        dec_o.link      = 1'b1;
        dec_o.reg_write = 1'b1;
        dec_o.imm       = imm_j;
      end
      OPC_JALR: begin
        dec_o.branch      = BR_JUMP;
        dec_o.jalr        = 1'b1;
        dec_o.link        = 1'b1;
        dec_o.alu_src_imm = 1'b1;
        dec_o.reg_write   = 1'b1;
        dec_o.imm         = imm_i;
      end
      OPC_BRANCH: begin
        dec_o.imm = imm_b;
        case (funct3)
          3'b000:  dec_o.branch = BR_EQ;
          3'b001:  dec_o.branch = BR_NE;
          3'b100:  dec_o.branch = BR_LT;
          3'b101:  dec_o.branch = BR_GE;
          3'b110:  dec_o.branch = BR_LTU;
          3'b111:  dec_o.branch = BR_GEU;
          default: dec_o.branch = BR_NONE;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        dec_o.alu_src_imm   = 1'b1;
        dec_o.mem_read      = (opcode == OPC_LOAD);
        dec_o.mem_write     = (opcode == OPC_STORE);
        dec_o.reg_write     = (opcode == OPC_LOAD);
        dec_o.load_unsigned = funct3[2];
        dec_o.imm           = (opcode == OPC_LOAD) ? imm_i : imm_s;
        dec_o.mem_width     = (funct3[1:0] == 2'b00) ? MW_BYTE :
                              (funct3[1:0] == 2'b01) ? MW_HALF : MW_WORD;
      end
      OPC_OP_IMM, OPC_OP: begin
        dec_o.alu_op      = arith_op;
        dec_o.alu_src_imm = (opcode == OPC_OP_IMM);
        dec_o.reg_write   = 1'b1;
        dec_o.imm         = imm_i;
      end
      // Only ECALL halts and other system encodings act as no-ops
      OPC_SYSTEM: dec_o.halt = (instr_i[31:7] == 25'd0);
      default: ;
    endcase
  end

endmodule

// ==== register_file.sv ====
// Integer register file with x0 tied to zero, two asynchronous reads and one clocked write
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  input  logic        we_i,
  input  logic [4:0]  rd_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata1_o,
  output logic [31:0] rdata2_o
);

  // x1 upwards, x0 has no storage
  logic [`CPU_XLEN-1:0] regs [1:`CPU_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// ==== result_stage.sv ====
// Store lane steering, load extraction and writeback select for the core
`timescale 1ns/1ps

module result_stage (
  input  cpu_pkg::decoded_t dec_i,
  input  logic [31:0]       alu_result_i,
  input  logic [31:0]       rs2_val_i,
  input  logic [31:0]       pc_i,
  input  logic [31:0]       load_data_i,
  output cpu_pkg::bus_req_t data_req_o,
  output logic [31:0]       wb_data_o
);
  import cpu_pkg::*;

  logic [1:0]  byte_off;
  logic [31:0] load_shifted;
  logic [31:0] load_val;

  assign byte_off = alu_result_i[1:0];

  // Word-aligned bus access with byte enables
  always_comb begin
    data_req_o.addr  = {alu_result_i[31:2], 2'b00};
    data_req_o.write = dec_i.mem_write;
    case (dec_i.mem_width)
      MW_BYTE: begin
        data_req_o.wdata = {4{rs2_val_i[7:0]}};
        data_req_o.sel   = 4'b0001 << byte_off;
      end
      MW_HALF: begin
        data_req_o.wdata = {2{rs2_val_i[15:0]}};
        data_req_o.sel   = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        data_req_o.wdata = rs2_val_i;
        data_req_o.sel   = 4'b1111;
      end
    endcase
  end

  // Bring the addressed lane down to bit 0
  assign load_shifted = load_data_i >> {byte_off, 3'b000};

  always_comb begin
    case (dec_i.mem_width)
      MW_BYTE: load_val = dec_i.load_unsigned ? {24'd0, load_shifted[7:0]} :
                          {{24{load_shifted[7]}}, load_shifted[7:0]};
      MW_HALF: load_val = dec_i.load_unsigned ? {16'd0, load_shifted[15:0]} :
                          {{16{load_shifted[15]}}, load_shifted[15:0]};
      default: load_val = load_data_i;
    endcase
  end

  always_comb begin
    if (dec_i.link) begin
      wb_data_o = pc_i + 32'd4;
    end else if (dec_i.mem_read) begin
      wb_data_o = load_val;
    end else begin
      wb_data_o = alu_result_i;
    end
  end

endmodule

// ==== tb_program.svh ====
// Stimulus table for the core testbench, program segments and expected stores, included in its body
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// One expected bus write: word address, write data, byte enables
typedef struct packed {
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  sel;
} store_rec_t;

localparam int NUM_SEGS   = 3;
localparam int PROG_WORDS = 76;
localparam int NUM_STORES = 23;

// Word preloaded at 0x100 for the load segment
localparam logic [31:0] DATA_WORD = 32'h80f2_7f91;

// Segment 0 ALU, segment 1 branches and jumps, segment 2 loads and narrow stores
int seg_base [NUM_SEGS] = '{0, 25, 60};
int seg_len [NUM_SEGS] = '{25, 35, 16};
int seg_store_base [NUM_SEGS] = '{0, 11, 15};
int seg_store_cnt [NUM_SEGS] = '{11, 4, 8};

logic [31:0] prog_rom [PROG_WORDS] = '{
  // ALU segment
  32'hff90_0093, 32'h0030_0113, 32'h4020_81b3, 32'h0021_1233,
  32'h4010_d293, 32'h01c0_d313, 32'h0020_a3b3, 32'h0020_b433,
  32'h0f00_c493, 32'h1234_5537, 32'h6785_6593, 32'h0015_f633,
  32'h0000_1697, 32'h2030_2023, 32'h2040_2223, 32'h2050_2423,
  32'h2060_2623, 32'h2070_2823, 32'h2080_2a23, 32'h2090_2c23,
  32'h20a0_2e23, 32'h22b0_2023, 32'h22c0_2223, 32'h22d0_2423,
  32'h0000_0073,
  // Branch segment, taken group then not-taken group
  32'hfff0_0093, 32'h0010_0113,
  32'h0010_8463, 32'h0012_8293, 32'h0020_9463, 32'h0022_8293,
  32'h0020_c463, 32'h0042_8293, 32'h0011_5463, 32'h0082_8293,
  32'h0011_6463, 32'h0102_8293, 32'h0020_f463, 32'h0202_8293,
  32'h0020_8463, 32'h0013_0313, 32'h0010_9463, 32'h0023_0313,
  32'h0011_4463, 32'h0043_0313, 32'h0020_d463, 32'h0083_0313,
  32'h0020_e463, 32'h0103_0313, 32'h0011_7463, 32'h0203_0313,
  // JAL at 0x68, JALR at 0x70
  32'h0080_03ef, 32'h0402_8293, 32'h00c3_8467, 32'h0802_8293,
  32'h2050_2023, 32'h2060_2223, 32'h2070_2423, 32'h2080_2623,
  32'h0000_0073,
  // Load and store segment
  32'h1000_0083, 32'h1010_4103, 32'h1020_1183, 32'h1000_5203,
  32'h1000_2283, 32'h1030_0303, 32'h2010_2023, 32'h2020_2223,
  32'h2030_2423, 32'h2040_2623, 32'h2050_08a3, 32'h2060_1b23,
  32'h2040_1c23, 32'h2110_4383, 32'h2070_2e23, 32'h0000_0073
};

store_rec_t exp_stores [NUM_STORES] = '{
  {32'h0000_0200, 32'hffff_fff6, 4'hf},
  {32'h0000_0204, 32'h0000_0018, 4'hf},
  {32'h0000_0208, 32'hffff_fffc, 4'hf},
  {32'h0000_020c, 32'h0000_000f, 4'hf},
  {32'h0000_0210, 32'h0000_0001, 4'hf},
  {32'h0000_0214, 32'h0000_0000, 4'hf},
  {32'h0000_0218, 32'hffff_ff09, 4'hf},
  {32'h0000_021c, 32'h1234_5000, 4'hf},
  {32'h0000_0220, 32'h1234_5678, 4'hf},
  {32'h0000_0224, 32'h1234_5678, 4'hf},
  {32'h0000_0228, 32'h0000_1030, 4'hf},
  {32'h0000_0200, 32'h0000_0000, 4'hf},
  {32'h0000_0204, 32'h0000_003f, 4'hf},
  {32'h0000_0208, 32'h0000_006c, 4'hf},
  {32'h0000_020c, 32'h0000_0074, 4'hf},
  {32'h0000_0200, 32'hffff_ff91, 4'hf},
  {32'h0000_0204, 32'h0000_007f, 4'hf},
  {32'h0000_0208, 32'hffff_80f2, 4'hf},
  {32'h0000_020c, 32'h0000_7f91, 4'hf},
  {32'h0000_0210, 32'h9191_9191, 4'h2},
  {32'h0000_0214, 32'hff80_ff80, 4'hc},
  {32'h0000_0218, 32'h7f91_7f91, 4'h3},
  {32'h0000_021c, 32'h0000_0091, 4'hf}
};

`endif

// ==== tb_cpu_top.sv ====
// Testbench for the RV32I core, plays the memory with random stalls and checks every bus write
`timescale 1ns/1ps

module tb_cpu_top;
  import cpu_pkg::*;

  `include "tb_program.svh"

  localparam int CLK_PERIOD   = 4;
  localparam int MEM_WORDS    = 256;
  localparam int WATCHDOG_CYC = PROG_WORDS * 40 + NUM_SEGS * 30;

  logic     clk;
  logic     rst_i;
  bus_req_t bus_req_o;
  logic     bus_req_valid_o;
  logic     bus_req_ready_i;
  logic     bus_rsp_valid_i;
  bus_rsp_t bus_rsp_i;
  logic     halted_o;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rng = 32'ha6eb_7f7f;
  logic [31:0] rsp_hold;
  logic [1:0]  delay_cnt;
  logic        pending;
  logic        stall_seen;
  bus_req_t    stalled_req;
  logic        first_req;
  int          store_idx;
  int          store_end;
  int          error_count = 0;

  cpu_top i_cpu_top (
    .clk             (clk),
    .rst_i           (rst_i),
    .bus_req_o       (bus_req_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .bus_rsp_i       (bus_rsp_i),
    .halted_o        (halted_o)
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift_next(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
    error_count++;
  endtask

  // Compare one accepted write with the next record of the segment
  task automatic check_store(input bus_req_t req);
    store_rec_t rec;
    if (store_idx >= store_end) begin
      $display("Unexpected extra store to %h at %0t ns", req.addr, $time);
      error_count++;
    end else begin
      rec = exp_stores[store_idx];
      if (req.addr !== rec.addr) begin
        report_mismatch("bus_req_o.addr", rec.addr, req.addr);
      end
      if (req.wdata !== rec.data) begin
        report_mismatch("bus_req_o.wdata", rec.data, req.wdata);
      end
      if (req.sel !== rec.sel) begin
        report_mismatch("bus_req_o.sel", {28'd0, rec.sel}, {28'd0, req.sel});
      end
      store_idx++;
    end
  endtask

  // Fill with an address-dependent pattern, then the program at 0 and the data word at 0x100
  task automatic load_memory(input int seg);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hbad0_0000 | i;
    end
    for (int i = 0; i < seg_len[seg]; i++) begin
      mem[i] = prog_rom[seg_base[seg] + i];
    end
    mem[64] = DATA_WORD;
  endtask

  // Memory model with random ready and response delay
  always @(posedge clk) begin
    rng = xorshift_next(rng);
    if (rst_i) begin
      bus_req_ready_i <= 1'b0;
      bus_rsp_valid_i <= 1'b0;
      pending         <= 1'b0;
      stall_seen      <= 1'b0;
      first_req       <= 1'b1;
    end else begin
      if (stall_seen) begin
        if (!bus_req_valid_o) begin
          $display("Request valid dropped while stalled at %0t ns", $time);
          error_count++;
        end else if (bus_req_o !== stalled_req) begin
          $display("CHECK FAILED at %0t ns: bus_req_o expected %h, got %h",
                   $time, stalled_req, bus_req_o);
          error_count++;
        end
      end
      stall_seen  <= bus_req_valid_o && !bus_req_ready_i;
      stalled_req <= bus_req_o;

      bus_rsp_valid_i <= 1'b0;
      if (pending) begin
        if (delay_cnt == 2'd0) begin
          bus_rsp_valid_i <= 1'b1;
          bus_rsp_i.rdata <= rsp_hold;
          pending         <= 1'b0;
        end else begin
          delay_cnt <= delay_cnt - 2'd1;
        end
      end

      if (bus_req_valid_o && bus_req_ready_i) begin
        if (first_req && (bus_req_o.addr !== 32'd0 || bus_req_o.write)) begin
          report_mismatch("bus_req_o.addr", 32'd0, bus_req_o.addr);
        end
        first_req <= 1'b0;
        if (bus_req_o.write) begin
          check_store(bus_req_o);
          for (int b = 0; b < 4; b++) begin
            if (bus_req_o.sel[b]) begin
              mem[bus_req_o.addr[9:2]][8*b +: 8] = bus_req_o.wdata[8*b +: 8];
            end
          end
        end
        rsp_hold  <= mem[bus_req_o.addr[9:2]];
        pending   <= 1'b1;
        delay_cnt <= rng[9:8];
      end

      // Ready high about three cycles in four
      bus_req_ready_i <= (rng[4:3] != 2'd0);
    end
  end

  initial begin
    rst_i           <= 1'b1;
    bus_req_ready_i <= 1'b0;
    bus_rsp_valid_i <= 1'b0;
    bus_rsp_i       <= '0;
    for (int s = 0; s < NUM_SEGS; s++) begin
      @(posedge clk);
      rst_i <= 1'b1;
      load_memory(s);
      store_idx = seg_store_base[s];
      store_end = seg_store_base[s] + seg_store_cnt[s];
      repeat (8) @(posedge clk);
      if (bus_req_valid_o !== 1'b0) begin
        report_mismatch("bus_req_valid_o", 32'd0, {31'd0, bus_req_valid_o});
      end
      if (halted_o !== 1'b0) begin
        report_mismatch("halted_o", 32'd0, {31'd0, halted_o});
      end
      rst_i <= 1'b0;
      @(posedge clk);
      while (halted_o !== 1'b1) begin
        @(posedge clk);
      end
      // Halted core stays quiet
      repeat (10) begin
        @(posedge clk);
        if (bus_req_valid_o !== 1'b0) begin
          $display("Request issued after halt in segment %0d at %0t ns", s, $time);
          error_count++;
        end
      end
      if (store_idx != store_end) begin
        $display("Segment %0d made %0d of %0d stores", s,
                 store_idx - seg_store_base[s], seg_store_cnt[s]);
        error_count++;
      end
    end
    $display("Checks done, errors: %0d", error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Watchdog expired, the core hung, errors: %0d", error_count);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
cpu_pkg.sv
instr_decode.sv
register_file.sv
execute_unit.sv
result_stage.sv
bus_request_unit.sv
core_sequencer.sv
cpu_top.sv
tb_cpu_top.sv
